// ==== filelist.f ====
+incdir+hdl
hdl/gb_io_pkg.sv
hdl/io_bus_decode.sv
hdl/div_prescaler.sv
hdl/tima_counter.sv
hdl/interrupt_ctrl.sv
hdl/timer_io_top.sv
verification/tb_clock_gen.sv
verification/timer_io_tb.sv

// ==== hdl/div_prescaler.sv ====
// Divider: free-running system counter, DIV byte and TAC-selected timer tick
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module div_prescaler
    import gb_io_pkg::*;
(
    input  logic     I_CLOCK,
    input  logic     I_RESET,
    input  logic     div_wr,
    input  tac_t     tac,
    output io_data_t div,
    output logic     tima_tick
);

    sys_count_t sys_count;
    logic       tap_sel;
    logic       tap_gated;
    logic       tap_prev;

    always_comb begin
        case (tac[1:0])
            2'd0:    tap_sel = sys_count[`GB_TAP_SEL0];
            2'd1:    tap_sel = sys_count[`GB_TAP_SEL1];
            2'd2:    tap_sel = sys_count[`GB_TAP_SEL2];
            default: tap_sel = sys_count[`GB_TAP_SEL3];
        endcase
    end

    // Disabling the timer also pulls the tap low, which can tick once
    assign tap_gated = tac[2] & tap_sel;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            sys_count <= '0;
            tap_prev  <= 1'b0;
            tima_tick <= 1'b0;
        end else begin
            if (div_wr) begin
                sys_count <= '0;
            end else begin
                sys_count <= sys_count + sys_count_t'(1);
            end
            tap_prev  <= tap_gated;
            // Falling edge of the gated tap
            tima_tick <= tap_prev & ~tap_gated;
        end
    end

    assign div = sys_count[15:8];

endmodule

// ==== hdl/gb_io_cfg.svh ====
// Timer I/O block configuration: register map, TAC taps and interrupt bit layout
`ifndef GB_IO_CFG_SVH
`define GB_IO_CFG_SVH

// CPU bus register map
`define GB_ADDR_DIV   16'hFF04
`define GB_ADDR_TIMA  16'hFF05
`define GB_ADDR_TMA   16'hFF06
`define GB_ADDR_TAC   16'hFF07
`define GB_ADDR_IF    16'hFF0F
`define GB_ADDR_IE    16'hFFFF

// Returned for any address outside the map
`define GB_UNMAPPED_DATA 8'hFF

// System counter bit watched for each TAC clock select
// Periods are 1024, 16, 64 and 256 clocks
`define GB_TAP_SEL0 9
`define GB_TAP_SEL1 3
`define GB_TAP_SEL2 5
`define GB_TAP_SEL3 7

// IF / IE bit positions
`define GB_IRQ_VBLANK 0
`define GB_IRQ_STAT   1
`define GB_IRQ_TIMER  2
`define GB_IRQ_SERIAL 3
`define GB_IRQ_JOYPAD 4

// Unused register bits read back as ones
`define GB_IF_PAD  3'b111
`define GB_TAC_PAD 5'b11111

`endif

// ==== hdl/gb_io_pkg.sv ====
// Shared bus, register and interrupt types for the timer I/O block
package gb_io_pkg;

    typedef logic [15:0] io_addr_t;
    typedef logic [7:0]  io_data_t;
    typedef logic [15:0] sys_count_t;

    // Bit 2 enables the timer, bits 1-0 pick the clock
    typedef logic [2:0]  tac_t;

    typedef logic [4:0]  irq_bits_t;
    // vblank, stat, serial, joypad from bit 0 upward
    typedef logic [3:0]  ext_irq_t;
    typedef logic [2:0]  irq_idx_t;

    typedef struct packed {
        logic     we;
        logic     re;
        io_addr_t addr;
        io_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic     div_wr;
        logic     tima_wr;
        logic     tma_wr;
        logic     tac_wr;
        logic     if_wr;
        logic     ie_wr;
        io_data_t wdata;
    } reg_wr_t;

    typedef struct packed {
        io_data_t div;
        io_data_t tima;
        io_data_t tma;
        tac_t     tac;
    } timer_regs_t;

    typedef struct packed {
        irq_bits_t if_bits;
        irq_bits_t ie_bits;
    } irq_regs_t;

endpackage

// ==== hdl/interrupt_ctrl.sv ====
// Interrupt controller: IF/IE registers, request capture, priority select and acknowledge
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module interrupt_ctrl
    import gb_io_pkg::*;
(
    input  logic      I_CLOCK,
    input  logic      I_RESET,
    input  reg_wr_t   reg_wr,
    input  logic      timer_req,
    input  ext_irq_t  ext_irq,
    input  logic      irq_ack,
    output irq_regs_t irq_regs,
    output logic      irq,
    output irq_idx_t  irq_vector
);

    irq_bits_t if_bits;
    irq_bits_t ie_bits;
    irq_bits_t pending;
    irq_bits_t req_set;
    irq_bits_t ack_clr;
    irq_bits_t if_base;

    // Place each request strobe on its IF bit
    always_comb begin
        req_set                 = '0;
        req_set[`GB_IRQ_VBLANK] = ext_irq[0];
        req_set[`GB_IRQ_STAT]   = ext_irq[1];
        req_set[`GB_IRQ_TIMER]  = timer_req;
        req_set[`GB_IRQ_SERIAL] = ext_irq[2];
        req_set[`GB_IRQ_JOYPAD] = ext_irq[3];
    end

    assign pending = if_bits & ie_bits;
    assign irq     = |pending;

    // Lowest index wins, so scan from the top down
    always_comb begin
        irq_vector = '0;
        for (int i = $bits(irq_bits_t) - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_vector = irq_idx_t'(i);
            end
        end
    end

    always_comb begin
        ack_clr = '0;
        if (irq_ack && irq) begin
            ack_clr[irq_vector] = 1'b1;
        end
    end

    assign if_base = reg_wr.if_wr ? reg_wr.wdata[4:0] : if_bits;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            if_bits <= '0;
            ie_bits <= '0;
        end else begin
            // New requests survive a clear in the same cycle
            if_bits <= (if_base & ~ack_clr) | req_set;
            if (reg_wr.ie_wr) begin
                ie_bits <= reg_wr.wdata[4:0];
            end
        end
    end

    assign irq_regs = '{if_bits: if_bits, ie_bits: ie_bits};

endmodule

// ==== hdl/io_bus_decode.sv ====
// Bus decoder: turns CPU requests into register write strobes and registered read data
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module io_bus_decode
    import gb_io_pkg::*;
(
    input  logic        I_CLOCK,
    input  logic        I_RESET,
    input  bus_req_t    bus_req,
    input  timer_regs_t timer_regs,
    input  irq_regs_t   irq_regs,
    output reg_wr_t     reg_wr,
    output io_data_t    rd_data,
    output logic        rd_valid
);

    io_data_t rd_sel;

    // Write strobes follow the request in the same cycle
    always_comb begin
        reg_wr       = '0;
        reg_wr.wdata = bus_req.wdata;
        if (bus_req.we) begin
            case (bus_req.addr)
                `GB_ADDR_DIV:  reg_wr.div_wr  = 1'b1;
                `GB_ADDR_TIMA: reg_wr.tima_wr = 1'b1;
                `GB_ADDR_TMA:  reg_wr.tma_wr  = 1'b1;
                `GB_ADDR_TAC:  reg_wr.tac_wr  = 1'b1;
                `GB_ADDR_IF:   reg_wr.if_wr   = 1'b1;
                `GB_ADDR_IE:   reg_wr.ie_wr   = 1'b1;
                default: ;
            endcase
        end
    end

    // Read select, with the hardware's ones in unused bits
    always_comb begin
        case (bus_req.addr)
            `GB_ADDR_DIV:  rd_sel = timer_regs.div;
            `GB_ADDR_TIMA: rd_sel = timer_regs.tima;
            `GB_ADDR_TMA:  rd_sel = timer_regs.tma;
            `GB_ADDR_TAC:  rd_sel = {`GB_TAC_PAD, timer_regs.tac};
            `GB_ADDR_IF:   rd_sel = {`GB_IF_PAD, irq_regs.if_bits};
            `GB_ADDR_IE:   rd_sel = {3'b000, irq_regs.ie_bits};
            default:       rd_sel = `GB_UNMAPPED_DATA;
        endcase
    end

    // Read data lands one cycle after the request
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            rd_data  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= bus_req.re;
            if (bus_req.re) begin
                rd_data <= rd_sel;
            end
        end
    end

endmodule

// ==== hdl/tima_counter.sv ====
// Timer counter: TIMA with TMA reload on overflow, TMA and TAC registers
`timescale 1ns/1ps

module tima_counter
    import gb_io_pkg::*;
(
    input  logic     I_CLOCK,
    input  logic     I_RESET,
    input  reg_wr_t  reg_wr,
    input  logic     tima_tick,
    output io_data_t tima,
    output io_data_t tma,
    output tac_t     tac,
    output logic     timer_req
);

    logic     overflow;
    io_data_t reload_val;

    assign overflow = tima_tick & (tima == 8'hFF) & ~reg_wr.tima_wr;

    // A TMA write in the overflow cycle feeds the reload directly
    assign reload_val = reg_wr.tma_wr ? reg_wr.wdata : tma;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tma <= '0;
            tac <= '0;
        end else begin
            if (reg_wr.tma_wr) begin
                tma <= reg_wr.wdata;
            end
            if (reg_wr.tac_wr) begin
                tac <= reg_wr.wdata[2:0];
            end
        end
    end

    // CPU write beats a tick in the same cycle
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tima <= '0;
        end else if (reg_wr.tima_wr) begin
            tima <= reg_wr.wdata;
        end else if (overflow) begin
            tima <= reload_val;
        end else if (tima_tick) begin
            tima <= tima + 8'd1;
        end
    end

    // Request pulse lines up with the reload
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            timer_req <= 1'b0;
        end else begin
            timer_req <= overflow;
        end
    end

endmodule

// ==== hdl/timer_io_top.sv ====
// Timer I/O top: bus decoder, divider, timer counter and interrupt controller
`timescale 1ns/1ps

module timer_io_top
    import gb_io_pkg::*;
(
    input  logic     I_CLOCK,
    input  logic     I_RESET,
    input  bus_req_t bus_req,
    input  ext_irq_t ext_irq,
    input  logic     irq_ack,
    output io_data_t rd_data,
    output logic     rd_valid,
    output logic     irq,
    output irq_idx_t irq_vector
);

    reg_wr_t     reg_wr;
    timer_regs_t timer_regs;
    irq_regs_t   irq_regs;
    io_data_t    div;
    io_data_t    tima;
    io_data_t    tma;
    tac_t        tac;
    logic        tima_tick;
    logic        timer_req;

    // Gather timer register values for the read path
    assign timer_regs = '{div: div, tima: tima, tma: tma, tac: tac};

    io_bus_decode u_decode (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .bus_req    (bus_req),
        .timer_regs (timer_regs),
        .irq_regs   (irq_regs),
        .reg_wr     (reg_wr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    div_prescaler u_prescaler (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .div_wr    (reg_wr.div_wr),
        .tac       (tac),
        .div       (div),
        .tima_tick (tima_tick)
    );

    tima_counter u_tima (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .reg_wr    (reg_wr),
        .tima_tick (tima_tick),
        .tima      (tima),
        .tma       (tma),
        .tac       (tac),
        .timer_req (timer_req)
    );

    interrupt_ctrl u_intc (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .reg_wr     (reg_wr),
        .timer_req  (timer_req),
        .ext_irq    (ext_irq),
        .irq_ack    (irq_ack),
        .irq_regs   (irq_regs),
        .irq        (irq),
        .irq_vector (irq_vector)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile the timer I/O testbench with Verilator and run it.
# The exit status is the simulator's own: nonzero after a $fatal.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=timer_io_sim

verilator --binary --timing \
    -f filelist.f \
    --top-module timer_io_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset source: 4 ns clock, reset held high for the first 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic I_CLOCK,
    output logic I_RESET
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 10;

    initial begin
        I_CLOCK = 1'b0;
        forever #(HALF_PERIOD_NS) I_CLOCK = ~I_CLOCK;
    end

    // Release reset just after an edge so nothing races with it
    initial begin
        I_RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge I_CLOCK);
        #1;
        I_RESET = 1'b0;
    end

endmodule

// ==== verification/timer_io_tb.sv ====
// Testbench for the timer I/O block that applies a stimulus table over the CPU bus
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module timer_io_tb
    import gb_io_pkg::*;
();

    localparam int          DRIVE_DELAY    = 1;
    localparam int          RESET_CYCLES   = 10;
    localparam int          RD_WAIT_LIMIT  = 4;
    localparam int          TIMEOUT_MARGIN = 200;
    localparam logic [31:0] RANDOM_SEED    = 32'ha0d19bc7;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_IDLE,
        OP_EXT_IRQ,
        OP_ACK,
        OP_IRQ_LEVEL
    } op_t;

    // Table row whose cycles field is used by idle rows only
    typedef struct packed {
        op_t         op;
        io_addr_t    addr;
        io_data_t    data;
        logic [15:0] cycles;
        io_data_t    exp_val;
    } step_t;

    logic     I_CLOCK;
    logic     I_RESET;
    bus_req_t bus_req;
    ext_irq_t ext_irq;
    logic     irq_ack;
    io_data_t rd_data;
    logic     rd_valid;
    logic     irq;
    irq_idx_t irq_vector;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    tb_clock_gen u_clock (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET)
    );

    timer_io_top uut (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .bus_req    (bus_req),
        .ext_irq    (ext_irq),
        .irq_ack    (irq_ack),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .irq        (irq),
        .irq_vector (irq_vector)
    );

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_data(io_data_t actual, io_data_t expected, io_addr_t addr);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: read of %h returned %h, expected %h",
                     $time, addr, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_valid(logic actual, logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: rd_valid is %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_vector(irq_idx_t actual, irq_idx_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: irq_vector is %0d, expected %0d", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_irq(logic actual, logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: irq is %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    function automatic step_t make_step(op_t op, io_addr_t addr, io_data_t data,
                                        logic [15:0] cycles, io_data_t exp_val);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.cycles  = cycles;
        s.exp_val = exp_val;
        return s;
    endfunction

    function automatic step_t write_step(io_addr_t addr, io_data_t data);
        return make_step(OP_WRITE, addr, data, 16'd0, 8'h00);
    endfunction

    function automatic step_t read_step(io_addr_t addr, io_data_t exp_val);
        return make_step(OP_READ, addr, 8'h00, 16'd0, exp_val);
    endfunction

    function automatic step_t idle_step(logic [15:0] cycles);
        return make_step(OP_IDLE, 16'h0000, 8'h00, cycles, 8'h00);
    endfunction

    function automatic step_t ext_pulse_step(ext_irq_t mask);
        return make_step(OP_EXT_IRQ, 16'h0000, {4'b0000, mask}, 16'd0, 8'h00);
    endfunction

    function automatic step_t ack_step(irq_idx_t vec);
        return make_step(OP_ACK, 16'h0000, 8'h00, 16'd0, {5'b00000, vec});
    endfunction

    function automatic step_t irq_level_step(logic level);
        return make_step(OP_IRQ_LEVEL, 16'h0000, 8'h00, 16'd0, {7'b0000000, level});
    endfunction

    task automatic build_table();
        io_data_t    tma_val;
        io_data_t    tac_val;
        io_data_t    ie_val;
        io_data_t    if_val;
        int          taps[4];
        int          mults[4];
        logic [15:0] period;
        tma_val = io_data_t'($urandom());
        tac_val = io_data_t'($urandom());
        ie_val  = io_data_t'($urandom());
        if_val  = io_data_t'($urandom());
        // Register readback with unused TAC and IF bits reading as ones
        steps.push_back(write_step(`GB_ADDR_TMA, tma_val));
        steps.push_back(write_step(`GB_ADDR_TAC, tac_val));
        steps.push_back(write_step(`GB_ADDR_IE, ie_val));
        steps.push_back(write_step(`GB_ADDR_IF, if_val));
        steps.push_back(read_step(`GB_ADDR_TMA, tma_val));
        steps.push_back(read_step(`GB_ADDR_TAC, {5'b11111, tac_val[2:0]}));
        steps.push_back(read_step(`GB_ADDR_IE, {3'b000, ie_val[4:0]}));
        steps.push_back(read_step(`GB_ADDR_IF, {3'b111, if_val[4:0]}));
        steps.push_back(read_step(16'hFF10, 8'hFF));
        // The divider read samples the count N cycles after the clear
        steps.push_back(write_step(`GB_ADDR_DIV, 8'h5A));
        steps.push_back(idle_step(16'd512));
        steps.push_back(read_step(`GB_ADDR_DIV, 8'h02));
        steps.push_back(write_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(read_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(write_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(idle_step(16'd255));
        steps.push_back(read_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(write_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(idle_step(16'd256));
        steps.push_back(read_step(`GB_ADDR_DIV, 8'h01));
        // Each tap period read sits half a period away from any tick
        taps  = '{9, 3, 5, 7};
        mults = '{2, 7, 5, 3};
        for (int sel = 0; sel < 4; sel++) begin
            period = 16'(1 << (taps[sel] + 1));
            steps.push_back(write_step(`GB_ADDR_TAC, 8'h00));
            steps.push_back(idle_step(16'd4));
            steps.push_back(write_step(`GB_ADDR_DIV, 8'h00));
            steps.push_back(write_step(`GB_ADDR_TIMA, 8'h00));
            steps.push_back(write_step(`GB_ADDR_TAC, io_data_t'(4 + sel)));
            steps.push_back(idle_step(16'(mults[sel] * int'(period) + int'(period) / 2)));
            steps.push_back(read_step(`GB_ADDR_TIMA, io_data_t'(mults[sel])));
        end
        // Overflow with a 16 clock period goes FE, FF, then reload
        steps.push_back(write_step(`GB_ADDR_TAC, 8'h00));
        steps.push_back(idle_step(16'd4));
        steps.push_back(write_step(`GB_ADDR_TMA, 8'hC0));
        steps.push_back(write_step(`GB_ADDR_IE, 8'h04));
        steps.push_back(write_step(`GB_ADDR_IF, 8'h00));
        steps.push_back(write_step(`GB_ADDR_DIV, 8'h00));
        steps.push_back(write_step(`GB_ADDR_TIMA, 8'hFE));
        steps.push_back(write_step(`GB_ADDR_TAC, 8'h05));
        steps.push_back(idle_step(16'd40));
        steps.push_back(irq_level_step(1'b1));
        steps.push_back(ack_step(3'd2));
        steps.push_back(irq_level_step(1'b0));
        steps.push_back(read_step(`GB_ADDR_TIMA, 8'hC0));
        steps.push_back(write_step(`GB_ADDR_TAC, 8'h00));
        // Vblank and serial pulsed together are served lowest index first
        steps.push_back(write_step(`GB_ADDR_IF, 8'h00));
        steps.push_back(write_step(`GB_ADDR_IE, 8'hFF));
        steps.push_back(ext_pulse_step(4'b0101));
        steps.push_back(irq_level_step(1'b1));
        steps.push_back(ack_step(3'd0));
        steps.push_back(ack_step(3'd3));
        steps.push_back(irq_level_step(1'b0));
        steps.push_back(read_step(`GB_ADDR_IF, 8'hE0));
    endtask

    function automatic int step_cost(step_t s);
        case (s.op)
            OP_IDLE: return int'(s.cycles);
            OP_READ: return 1 + RD_WAIT_LIMIT;
            default: return 1;
        endcase
    endfunction

    function automatic int table_cycles();
        int total;
        total = 0;
        foreach (steps[i]) begin
            total += step_cost(steps[i]);
        end
        return total;
    endfunction

    // Inputs change a fixed delay after the edge and default to idle
    task automatic next_cycle();
        @(posedge I_CLOCK);
        #(DRIVE_DELAY);
        bus_req = '0;
        ext_irq = '0;
        irq_ack = 1'b0;
    endtask

    task automatic run_step(step_t s);
        int waited;
        case (s.op)
            OP_WRITE: begin
                next_cycle();
                bus_req.we    = 1'b1;
                bus_req.addr  = s.addr;
                bus_req.wdata = s.data;
            end
            OP_READ: begin
                next_cycle();
                // No read was issued in the previous cycle, so rd_valid is low
                check_valid(rd_valid, 1'b0);
                bus_req.re   = 1'b1;
                bus_req.addr = s.addr;
                next_cycle();
                waited = 0;
                while (!rd_valid && waited < RD_WAIT_LIMIT) begin
                    next_cycle();
                    waited++;
                end
                if (!rd_valid) begin
                    $display("Read of %h got no rd_valid within %0d cycles", s.addr, waited);
                    abort_run();
                end else begin
                    check_data(rd_data, s.exp_val, s.addr);
                end
            end
            OP_IDLE: begin
                repeat (s.cycles) next_cycle();
            end
            OP_EXT_IRQ: begin
                next_cycle();
                ext_irq = s.data[3:0];
            end
            OP_ACK: begin
                next_cycle();
                // The vector is stable here and the acknowledge lands at the next edge
                irq_ack = 1'b1;
                check_vector(irq_vector, s.exp_val[2:0]);
            end
            OP_IRQ_LEVEL: begin
                next_cycle();
                check_irq(irq, s.exp_val[0]);
            end
            default: ;
        endcase
    endtask

    always @(posedge I_CLOCK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        bus_req = '0;
        ext_irq = '0;
        irq_ack = 1'b0;
        void'($urandom(RANDOM_SEED));
        build_table();
        cycle_limit = RESET_CYCLES + table_cycles() + TIMEOUT_MARGIN;
        @(negedge I_RESET);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule
